// ==== design/iew_config.svh ====
`ifndef IEW_CONFIG_SVH
`define IEW_CONFIG_SVH

// Datapath width
`define IEW_XLEN      32

// Physical and architectural register counts
`define IEW_NR_PREGS  64
`define IEW_NR_AREGS  32

// Reorder buffer entries, must stay a power of two
`define IEW_ROB_DEPTH 8

// Functional units fed by issue
`define IEW_NR_FU     4

// Instruction sequence number width
`define IEW_ID_BITS   8

`endif

// ==== design/iew_pkg.sv ====
`default_nettype none

`include "iew_config.svh"

package iew_pkg;

    typedef logic [`IEW_XLEN-1:0]              xlen_t;
    typedef logic [$clog2(`IEW_NR_PREGS)-1:0]  preg_id_t;
    typedef logic [$clog2(`IEW_NR_AREGS)-1:0]  areg_id_t;
    typedef logic [$clog2(`IEW_ROB_DEPTH)-1:0] rob_id_t;
    typedef logic [`IEW_ID_BITS-1:0]           inst_id_t;
    // One ready bit per functional unit, indexed by fu_t
    typedef logic [`IEW_NR_FU-1:0]             fu_ready_t;

    typedef enum logic [1:0] {
        FU_ALU,
        FU_MUL,
        FU_LSU,
        FU_BRU
    } fu_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_AUIPC
    } alu_op_t;

endpackage

`default_nettype wire

// ==== design/iew_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "iew_config.svh"

module iew_top import iew_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    // Renamed instruction in
    input  wire             di_valid_i,
    input  wire inst_id_t   di_id_i,
    input  wire xlen_t      di_pc_i,
    input  wire xlen_t      di_imm_i,
    input  wire fu_t        di_fu_i,
    input  wire alu_op_t    di_op_i,
    input  wire areg_id_t   di_rs1_i,
    input  wire areg_id_t   di_rs2_i,
    input  wire areg_id_t   di_rd_i,
    input  wire             di_rs1_valid_i,
    input  wire             di_rs2_valid_i,
    input  wire             di_use_uimm_i,
    input  wire preg_id_t   di_prs1_i,
    input  wire preg_id_t   di_prs2_i,
    input  wire             di_prs1_renamed_i,
    input  wire             di_prs2_renamed_i,
    input  wire             di_rd_valid_i,
    input  wire preg_id_t   di_prd_i,
    output logic            di_ready_o,
    // Execute side
    input  wire fu_ready_t  fu_ready_i,
    output logic            fu_valid_o,
    output xlen_t           fu_pc_o,
    output inst_id_t        fu_id_o,
    output preg_id_t        fu_prd_o,
    output xlen_t           fu_rs1val_o,
    output xlen_t           fu_rs2val_o,
    output xlen_t           fu_imm_o,
    output fu_t             fu_fu_o,
    output alu_op_t         fu_op_o,
    output rob_id_t         fu_rob_id_o,
    // Bypass, writeback and completion
    input  wire             byp_valid_i,
    input  wire preg_id_t   byp_prd_i,
    input  wire xlen_t      byp_rdval_i,
    input  wire             wb_valid_i,
    input  wire preg_id_t   wb_prd_i,
    input  wire xlen_t      wb_rdval_i,
    input  wire             cmpl_valid_i,
    input  wire rob_id_t    cmpl_id_i,
    // Retired instruction out
    output logic            retire_valid_o,
    output inst_id_t        retire_id_o,
    output xlen_t           retire_pc_o,
    output areg_id_t        retire_ard_o,
    output preg_id_t        retire_prd_o,
    output logic            retire_rd_write_o,
    output xlen_t           retire_rdval_o
);

    // PRF ports 0 and 1 for issue, port 2 for retire
    preg_id_t [2:0] prf_raddr;
    xlen_t    [2:0] prf_rdata;
    areg_id_t [1:0] arf_raddr;
    xlen_t    [1:0] arf_rdata;
    logic           arf_we;
    areg_id_t       arf_waddr;
    xlen_t          arf_wdata;
    logic           rob_ready;

    rob_head_if head_if ();

    regfile #(
        .WIDTH  (`IEW_XLEN),
        .NREGS  (`IEW_NR_PREGS),
        .NREAD  (3),
        .NWRITE (1)
    ) prf (
        .clk     (clk),
        .rstn    (rstn),
        .we_i    (wb_valid_i),
        .waddr_i (wb_prd_i),
        .wdata_i (wb_rdval_i),
        .raddr_i (prf_raddr),
        .rdata_o (prf_rdata)
    );

    regfile #(
        .WIDTH  (`IEW_XLEN),
        .NREGS  (`IEW_NR_AREGS),
        .NREAD  (2),
        .NWRITE (1)
    ) arf (
        .clk     (clk),
        .rstn    (rstn),
        .we_i    (arf_we),
        .waddr_i (arf_waddr),
        .wdata_i (arf_wdata),
        .raddr_i (arf_raddr),
        .rdata_o (arf_rdata)
    );

    operand_read operand_read_inst (
        .clk               (clk),
        .rstn              (rstn),
        .di_valid_i        (di_valid_i),
        .di_pc_i           (di_pc_i),
        .di_imm_i          (di_imm_i),
        .di_fu_i           (di_fu_i),
        .di_op_i           (di_op_i),
        .di_rs1_i          (di_rs1_i),
        .di_rs2_i          (di_rs2_i),
        .di_rs1_valid_i    (di_rs1_valid_i),
        .di_rs2_valid_i    (di_rs2_valid_i),
        .di_use_uimm_i     (di_use_uimm_i),
        .di_prs1_i         (di_prs1_i),
        .di_prs2_i         (di_prs2_i),
        .di_prs1_renamed_i (di_prs1_renamed_i),
        .di_prs2_renamed_i (di_prs2_renamed_i),
        .di_rd_valid_i     (di_rd_valid_i),
        .di_prd_i          (di_prd_i),
        .prf_rdata_i       (prf_rdata[1:0]),
        .arf_rdata_i       (arf_rdata),
        .byp_valid_i       (byp_valid_i),
        .byp_prd_i         (byp_prd_i),
        .byp_rdval_i       (byp_rdval_i),
        .wb_valid_i        (wb_valid_i),
        .wb_prd_i          (wb_prd_i),
        .fu_ready_i        (fu_ready_i),
        .rob_ready_i       (rob_ready),
        .prf_raddr_o       (prf_raddr[1:0]),
        .arf_raddr_o       (arf_raddr),
        .rs1val_o          (fu_rs1val_o),
        .rs2val_o          (fu_rs2val_o),
        .fu_valid_o        (fu_valid_o),
        .di_ready_o        (di_ready_o)
    );

    // Every issued instruction takes a ROB slot
    rob rob_inst (
        .clk             (clk),
        .rstn            (rstn),
        .push_i          (fu_valid_o),
        .push_id_i       (di_id_i),
        .push_pc_i       (di_pc_i),
        .push_prd_i      (di_prd_i),
        .push_ard_i      (di_rd_i),
        .push_rd_write_i (di_rd_valid_i),
        .cmpl_valid_i    (cmpl_valid_i),
        .cmpl_id_i       (cmpl_id_i),
        .head            (head_if.rob_side),
        .ready_o         (rob_ready),
        .alloc_id_o      (fu_rob_id_o)
    );

    retire_commit retire_commit_inst (
        .clk               (clk),
        .rstn              (rstn),
        .head              (head_if.retire_side),
        .prf_rdata_i       (prf_rdata[2]),
        .prf_raddr_o       (prf_raddr[2]),
        .arf_we_o          (arf_we),
        .arf_waddr_o       (arf_waddr),
        .arf_wdata_o       (arf_wdata),
        .retire_valid_o    (retire_valid_o),
        .retire_id_o       (retire_id_o),
        .retire_pc_o       (retire_pc_o),
        .retire_ard_o      (retire_ard_o),
        .retire_prd_o      (retire_prd_o),
        .retire_rd_write_o (retire_rd_write_o),
        .retire_rdval_o    (retire_rdval_o)
    );

    // Instruction fields travel unchanged to execute
    assign fu_pc_o  = di_pc_i;
    assign fu_id_o  = di_id_i;
    assign fu_prd_o = di_prd_i;
    assign fu_imm_o = di_imm_i;
    assign fu_fu_o  = di_fu_i;
    assign fu_op_o  = di_op_i;

endmodule

`default_nettype wire

// ==== design/operand_read.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "iew_config.svh"

module operand_read import iew_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    input  wire             di_valid_i,
    input  wire xlen_t      di_pc_i,
    input  wire xlen_t      di_imm_i,
    input  wire fu_t        di_fu_i,
    input  wire alu_op_t    di_op_i,
    input  wire areg_id_t   di_rs1_i,
    input  wire areg_id_t   di_rs2_i,
    input  wire             di_rs1_valid_i,
    input  wire             di_rs2_valid_i,
    input  wire             di_use_uimm_i,
    input  wire preg_id_t   di_prs1_i,
    input  wire preg_id_t   di_prs2_i,
    input  wire             di_prs1_renamed_i,
    input  wire             di_prs2_renamed_i,
    input  wire             di_rd_valid_i,
    input  wire preg_id_t   di_prd_i,
    input  wire xlen_t [1:0] prf_rdata_i,
    input  wire xlen_t [1:0] arf_rdata_i,
    input  wire             byp_valid_i,
    input  wire preg_id_t   byp_prd_i,
    input  wire xlen_t      byp_rdval_i,
    input  wire             wb_valid_i,
    input  wire preg_id_t   wb_prd_i,
    input  wire fu_ready_t  fu_ready_i,
    input  wire             rob_ready_i,
    output preg_id_t [1:0]  prf_raddr_o,
    output areg_id_t [1:0]  arf_raddr_o,
    output xlen_t           rs1val_o,
    output xlen_t           rs2val_o,
    output logic            fu_valid_o,
    output logic            di_ready_o
);

    logic [1:0]     renamed;
    logic [1:0]     sb_ready;
    xlen_t [1:0]    src_val;
    logic [1:0]     src_ok;
    logic           rs1_ok;
    logic           rs2_ok;
    logic [1:0]     sb_we;
    preg_id_t [1:0] sb_waddr;
    logic [1:0]     sb_wdata;

    assign renamed     = {di_prs2_renamed_i, di_prs1_renamed_i};
    assign prf_raddr_o = {di_prs2_i, di_prs1_i};
    assign arf_raddr_o = {di_rs2_i, di_rs1_i};

    // One bit per physical register, set means the value is in the PRF
    regfile #(
        .WIDTH  (1),
        .NREGS  (`IEW_NR_PREGS),
        .NREAD  (2),
        .NWRITE (2)
    ) scoreboard (
        .clk     (clk),
        .rstn    (rstn),
        .we_i    (sb_we),
        .waddr_i (sb_waddr),
        .wdata_i (sb_wdata),
        .raddr_i (prf_raddr_o),
        .rdata_o (sb_ready)
    );

    // ARF for plain sources, else bypass, else PRF gated by scoreboard
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (!renamed[i]) begin
                src_val[i] = arf_rdata_i[i];
                src_ok[i]  = 1'b1;
            end else if (byp_valid_i && byp_prd_i == prf_raddr_o[i]) begin
                src_val[i] = byp_rdval_i;
                src_ok[i]  = 1'b1;
            end else begin
                src_val[i] = prf_rdata_i[i];
                src_ok[i]  = sb_ready[i];
            end
        end
    end

    always_comb begin
        rs1val_o = '0;
        rs1_ok   = 1'b1;
        if (di_fu_i == FU_ALU && di_op_i == ALU_AUIPC) begin
            rs1val_o = di_pc_i;
        end else if (di_use_uimm_i) begin
            rs1val_o = xlen_t'(di_rs1_i);
        end else if (di_rs1_valid_i) begin
            rs1val_o = src_val[0];
            rs1_ok   = src_ok[0];
        end

        // Immediate replaces a missing rs2
        rs2val_o = di_imm_i;
        rs2_ok   = 1'b1;
        if (di_rs2_valid_i) begin
            rs2val_o = src_val[1];
            rs2_ok   = src_ok[1];
        end
    end

    assign di_ready_o = !di_valid_i ||
                        (rs1_ok && rs2_ok && fu_ready_i[di_fu_i] && rob_ready_i);
    assign fu_valid_o = di_valid_i && di_ready_o;

    // Port 0 clears on issue, port 1 sets on writeback
    // Writeback to the same register suppresses the clear
    assign sb_we[0]    = fu_valid_o && di_rd_valid_i &&
                         !(wb_valid_i && wb_prd_i == di_prd_i);
    assign sb_waddr[0] = di_prd_i;
    assign sb_wdata[0] = 1'b0;
    assign sb_we[1]    = wb_valid_i;
    assign sb_waddr[1] = wb_prd_i;
    assign sb_wdata[1] = 1'b1;

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regfile #(
    parameter int   WIDTH  = 32,
    parameter int   NREGS  = 32,
    parameter int   NREAD  = 2,
    parameter int   NWRITE = 1,
    localparam int  ABITS  = $clog2(NREGS)
) (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire [NWRITE-1:0]                 we_i,
    input  wire [NWRITE-1:0][ABITS-1:0]      waddr_i,
    input  wire [NWRITE-1:0][WIDTH-1:0]      wdata_i,
    input  wire [NREAD-1:0][ABITS-1:0]       raddr_i,
    output logic [NREAD-1:0][WIDTH-1:0]      rdata_o
);

    logic [NREGS-1:0][WIDTH-1:0] regs;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            regs <= '0;
        end else begin
            // Later ports take priority on a shared address
            for (int w = 0; w < NWRITE; w++) begin
                if (we_i[w]) begin
                    regs[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // Reads see stored state only
    always_comb begin
        for (int r = 0; r < NREAD; r++) begin
            rdata_o[r] = regs[raddr_i[r]];
        end
    end

    for (genvar a = 0; a < NWRITE; a++) begin : g_wr_a
        for (genvar b = a + 1; b < NWRITE; b++) begin : g_wr_b
            // Callers must resolve colliding writes themselves
            assert property (@(posedge clk) disable iff (!rstn)
                (we_i[a] && we_i[b] && waddr_i[a] == waddr_i[b])
                    |-> wdata_i[a] == wdata_i[b])
                else $error("regfile: conflicting writes to one address");
        end
    end

endmodule

`default_nettype wire

// ==== design/retire_commit.sv ====
`timescale 1ns/1ns
`default_nettype none

module retire_commit import iew_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    rob_head_if.retire_side head,
    input  wire xlen_t      prf_rdata_i,
    output preg_id_t        prf_raddr_o,
    output logic            arf_we_o,
    output areg_id_t        arf_waddr_o,
    output xlen_t           arf_wdata_o,
    output logic            retire_valid_o,
    output inst_id_t        retire_id_o,
    output xlen_t           retire_pc_o,
    output areg_id_t        retire_ard_o,
    output preg_id_t        retire_prd_o,
    output logic            retire_rd_write_o,
    output xlen_t           retire_rdval_o
);

    // Retire never stalls, a completed head leaves at once
    assign head.pop    = head.head_valid;
    assign prf_raddr_o = head.head_prd;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= head.head_valid;
        end
    end

    // Result is already in the PRF by the time the head completes
    always_ff @(posedge clk) begin
        if (head.head_valid) begin
            retire_id_o       <= head.head_id;
            retire_pc_o       <= head.head_pc;
            retire_ard_o      <= head.head_ard;
            retire_prd_o      <= head.head_prd;
            retire_rd_write_o <= head.head_rd_write;
            retire_rdval_o    <= prf_rdata_i;
        end
    end

    // Commit to architectural state
    assign arf_we_o    = retire_valid_o && retire_rd_write_o;
    assign arf_waddr_o = retire_ard_o;
    assign arf_wdata_o = retire_rdval_o;

endmodule

`default_nettype wire

// ==== design/rob.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "iew_config.svh"

module rob import iew_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    input  wire             push_i,
    input  wire inst_id_t   push_id_i,
    input  wire xlen_t      push_pc_i,
    input  wire preg_id_t   push_prd_i,
    input  wire areg_id_t   push_ard_i,
    input  wire             push_rd_write_i,
    input  wire             cmpl_valid_i,
    input  wire rob_id_t    cmpl_id_i,
    rob_head_if.rob_side    head,
    output logic            ready_o,
    output rob_id_t         alloc_id_o
);

    localparam int DEPTH = `IEW_ROB_DEPTH;

    inst_id_t         ent_id  [DEPTH];
    xlen_t            ent_pc  [DEPTH];
    preg_id_t         ent_prd [DEPTH];
    areg_id_t         ent_ard [DEPTH];
    logic [DEPTH-1:0] ent_rd_write;
    logic [DEPTH-1:0] allocated;
    logic [DEPTH-1:0] completed;
    rob_id_t          issue_ptr;
    rob_id_t          retire_ptr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            allocated  <= '0;
            completed  <= '0;
            issue_ptr  <= '0;
            retire_ptr <= '0;
        end else begin
            if (push_i) begin
                allocated[issue_ptr] <= 1'b1;
                completed[issue_ptr] <= 1'b0;
                issue_ptr            <= issue_ptr + rob_id_t'(1);
            end
            if (cmpl_valid_i) begin
                completed[cmpl_id_i] <= 1'b1;
            end
            // Pointers wrap with the index width
            if (head.pop) begin
                allocated[retire_ptr] <= 1'b0;
                retire_ptr            <= retire_ptr + rob_id_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            ent_id[issue_ptr]       <= push_id_i;
            ent_pc[issue_ptr]       <= push_pc_i;
            ent_prd[issue_ptr]      <= push_prd_i;
            ent_ard[issue_ptr]      <= push_ard_i;
            ent_rd_write[issue_ptr] <= push_rd_write_i;
        end
    end

    // Full when the next slot is still in flight
    assign ready_o    = !allocated[issue_ptr];
    assign alloc_id_o = issue_ptr;

    assign head.head_valid    = allocated[retire_ptr] && completed[retire_ptr];
    assign head.head_id       = ent_id[retire_ptr];
    assign head.head_pc       = ent_pc[retire_ptr];
    assign head.head_prd      = ent_prd[retire_ptr];
    assign head.head_ard      = ent_ard[retire_ptr];
    assign head.head_rd_write = ent_rd_write[retire_ptr];

    assert property (@(posedge clk) disable iff (!rstn)
        push_i |-> !allocated[issue_ptr])
        else $error("rob: push into an allocated slot");

    assert property (@(posedge clk) disable iff (!rstn)
        head.pop |-> allocated[retire_ptr] && completed[retire_ptr])
        else $error("rob: pop of an uncompleted entry");

    assert property (@(posedge clk) disable iff (!rstn)
        cmpl_valid_i |-> allocated[cmpl_id_i])
        else $error("rob: completion of an unallocated slot");

endmodule

`default_nettype wire

// ==== design/rob_head_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface rob_head_if import iew_pkg::*; ();

    // Head entry is allocated and completed
    logic     head_valid;
    inst_id_t head_id;
    xlen_t    head_pc;
    preg_id_t head_prd;
    areg_id_t head_ard;
    logic     head_rd_write;
    // Head leaves the ROB at this edge
    logic     pop;

    modport rob_side (
        output head_valid, head_id, head_pc, head_prd, head_ard, head_rd_write,
        input  pop
    );

    modport retire_side (
        input  head_valid, head_id, head_pc, head_prd, head_ard, head_rd_write,
        output pop
    );

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_iew \
    -o Vtb_iew

./obj_dir/Vtb_iew

// ==== src.f ====
+incdir+design
design/iew_pkg.sv
design/regfile.sv
design/rob_head_if.sv
design/operand_read.sv
design/rob.sv
design/retire_commit.sv
design/iew_top.sv
testbench/tb_iew.sv

// ==== testbench/tb_iew.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "iew_config.svh"

module tb_iew import iew_pkg::*; ();

    localparam int DEPTH          = `IEW_ROB_DEPTH;
    // Wide margin over the roughly hundred cycles of the five tests
    localparam int TIMEOUT_CYCLES = 2000;

    logic      clk;
    logic      rstn;
    logic      di_valid_i;
    inst_id_t  di_id_i;
    xlen_t     di_pc_i;
    xlen_t     di_imm_i;
    fu_t       di_fu_i;
    alu_op_t   di_op_i;
    areg_id_t  di_rs1_i;
    areg_id_t  di_rs2_i;
    areg_id_t  di_rd_i;
    logic      di_rs1_valid_i;
    logic      di_rs2_valid_i;
    logic      di_use_uimm_i;
    preg_id_t  di_prs1_i;
    preg_id_t  di_prs2_i;
    logic      di_prs1_renamed_i;
    logic      di_prs2_renamed_i;
    logic      di_rd_valid_i;
    preg_id_t  di_prd_i;
    logic      di_ready_o;
    fu_ready_t fu_ready_i;
    logic      fu_valid_o;
    xlen_t     fu_pc_o;
    inst_id_t  fu_id_o;
    preg_id_t  fu_prd_o;
    xlen_t     fu_rs1val_o;
    xlen_t     fu_rs2val_o;
    xlen_t     fu_imm_o;
    fu_t       fu_fu_o;
    alu_op_t   fu_op_o;
    rob_id_t   fu_rob_id_o;
    logic      byp_valid_i;
    preg_id_t  byp_prd_i;
    xlen_t     byp_rdval_i;
    logic      wb_valid_i;
    preg_id_t  wb_prd_i;
    xlen_t     wb_rdval_i;
    logic      cmpl_valid_i;
    rob_id_t   cmpl_id_i;
    logic      retire_valid_o;
    inst_id_t  retire_id_o;
    xlen_t     retire_pc_o;
    areg_id_t  retire_ard_o;
    preg_id_t  retire_prd_o;
    logic      retire_rd_write_o;
    xlen_t     retire_rdval_o;

    logic [31:0] rng_state = 32'd27;
    int          cycle_count = 0;
    int          issued_count = 0;
    int          retired_count = 0;
    // Issued but not yet completed
    rob_id_t     pending [$];

    iew_top iew_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Finished with errors");
            $fatal(1, "simulation timed out");
        end
    end

    // Count each retire pulse at the edge that ends it
    always @(posedge clk) begin
        if (retire_valid_o) begin
            retired_count++;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic idle_inputs();
        di_valid_i        = 1'b0;
        di_id_i           = '0;
        di_pc_i           = '0;
        di_imm_i          = '0;
        di_fu_i           = FU_ALU;
        di_op_i           = ALU_ADD;
        di_rs1_i          = '0;
        di_rs2_i          = '0;
        di_rd_i           = '0;
        di_rs1_valid_i    = 1'b0;
        di_rs2_valid_i    = 1'b0;
        di_use_uimm_i     = 1'b0;
        di_prs1_i         = '0;
        di_prs2_i         = '0;
        di_prs1_renamed_i = 1'b0;
        di_prs2_renamed_i = 1'b0;
        di_rd_valid_i     = 1'b0;
        di_prd_i          = '0;
        fu_ready_i        = '1;
        byp_valid_i       = 1'b0;
        byp_prd_i         = '0;
        byp_rdval_i       = '0;
        wb_valid_i        = 1'b0;
        wb_prd_i          = '0;
        wb_rdval_i        = '0;
        cmpl_valid_i      = 1'b0;
        cmpl_id_i         = '0;
    endtask

    // ALU add with no sources and no destination
    task automatic present_plain(input inst_id_t id, input xlen_t pc);
        idle_inputs();
        di_valid_i = 1'b1;
        di_id_i    = id;
        di_pc_i    = pc;
        di_imm_i   = next_random();
    endtask

    task automatic issue_now(output rob_id_t rid);
        #1;
        check_value(32'(fu_valid_o), 32'd1, "instruction did not issue");
        // ROB slots are handed out in order from zero after reset
        check_value(32'(fu_rob_id_o), 32'(issued_count % DEPTH), "fu_rob_id_o");
        check_value(fu_pc_o, di_pc_i, "fu_pc_o");
        check_value(32'(fu_id_o), 32'(di_id_i), "fu_id_o");
        check_value(32'(fu_prd_o), 32'(di_prd_i), "fu_prd_o");
        check_value(fu_imm_o, di_imm_i, "fu_imm_o");
        check_value(32'(fu_fu_o), 32'(di_fu_i), "fu_fu_o");
        check_value(32'(fu_op_o), 32'(di_op_i), "fu_op_o");
        rid = fu_rob_id_o;
        issued_count++;
        @(negedge clk);
        di_valid_i = 1'b0;
    endtask

    task automatic complete_entry(input rob_id_t rid);
        cmpl_valid_i = 1'b1;
        cmpl_id_i    = rid;
        @(negedge clk);
        cmpl_valid_i = 1'b0;
    endtask

    task automatic drain_rob();
        idle_inputs();
        while (pending.size() > 0) begin
            complete_entry(pending.pop_front());
        end
        while (retired_count != issued_count) begin
            @(negedge clk);
        end
    endtask

    task automatic reset_and_operand_select();
        rob_id_t rid;
        check_value(32'(fu_valid_o), 32'd0, "fu_valid_o after reset");
        check_value(32'(retire_valid_o), 32'd0, "retire_valid_o after reset");
        check_value(32'(di_ready_o), 32'd1, "di_ready_o while idle");
        // Plain rs1 from the zeroed ARF and the immediate as rs2
        present_plain(8'h10, 32'h0000_0800);
        di_rs1_valid_i = 1'b1;
        di_rs1_i       = 5'd5;
        #1;
        check_value(32'(di_ready_o), 32'd1, "di_ready_o for plain sources");
        check_value(fu_rs1val_o, 32'd0, "rs1 from the ARF after reset");
        check_value(fu_rs2val_o, di_imm_i, "rs2 should be the immediate");
        issue_now(rid);
        pending.push_back(rid);
        // AUIPC takes the pc
        present_plain(8'h11, next_random());
        di_op_i        = ALU_AUIPC;
        di_rs1_valid_i = 1'b1;
        di_rs1_i       = 5'd3;
        #1;
        check_value(fu_rs1val_o, di_pc_i, "rs1 should be the pc for AUIPC");
        issue_now(rid);
        pending.push_back(rid);
        // Unsigned immediate from the rs1 index
        present_plain(8'h12, 32'h0000_0808);
        di_use_uimm_i = 1'b1;
        di_rs1_i      = 5'd19;
        #1;
        check_value(fu_rs1val_o, 32'd19, "rs1 should be the rs1 index");
        issue_now(rid);
        pending.push_back(rid);
        drain_rob();
    endtask

    task automatic write_complete_commit();
        rob_id_t rid;
        xlen_t   value;
        value = next_random();
        present_plain(8'h21, 32'h0000_1000);
        di_rd_valid_i = 1'b1;
        di_rd_i       = 5'd7;
        di_prd_i      = 6'd10;
        issue_now(rid);
        wb_valid_i = 1'b1;
        wb_prd_i   = 6'd10;
        wb_rdval_i = value;
        @(negedge clk);
        wb_valid_i = 1'b0;
        complete_entry(rid);
        check_value(32'(retire_valid_o), 32'd0, "retire_valid_o one edge after completion");
        @(negedge clk);
        check_value(32'(retire_valid_o), 32'd1, "retire_valid_o two edges after completion");
        check_value(32'(retire_id_o), 32'h21, "retire_id_o");
        check_value(32'(retire_ard_o), 32'd7, "retire_ard_o");
        check_value(32'(retire_prd_o), 32'd10, "retire_prd_o");
        check_value(retire_pc_o, 32'h0000_1000, "retire_pc_o");
        check_value(32'(retire_rd_write_o), 32'd1, "retire_rd_write_o");
        check_value(retire_rdval_o, value, "retire_rdval_o");
        @(negedge clk);
        check_value(32'(retire_valid_o), 32'd0, "retire_valid_o lasts one cycle");
        // Committed value now in the ARF
        di_rs1_valid_i = 1'b1;
        di_rs1_i       = 5'd7;
        #1;
        check_value(fu_rs1val_o, value, "ARF read after commit");
        drain_rob();
    endtask

    task automatic scoreboard_stall_bypass();
        rob_id_t rid;
        xlen_t   value;
        value = next_random();
        // New producer of p10, which is ready from the previous test
        present_plain(8'h30, 32'h0000_1100);
        di_rd_valid_i = 1'b1;
        di_rd_i       = 5'd9;
        di_prd_i      = 6'd10;
        issue_now(rid);
        pending.push_back(rid);
        present_plain(8'h31, 32'h0000_1104);
        di_rs1_valid_i    = 1'b1;
        di_rs1_i          = 5'd9;
        di_prs1_i         = 6'd10;
        di_prs1_renamed_i = 1'b1;
        #1;
        check_value(32'(di_ready_o), 32'd0, "di_ready_o with p10 not ready");
        check_value(32'(fu_valid_o), 32'd0, "fu_valid_o with p10 not ready");
        @(negedge clk);
        check_value(32'(di_ready_o), 32'd0, "di_ready_o still stalled");
        byp_valid_i = 1'b1;
        byp_prd_i   = 6'd10;
        byp_rdval_i = value;
        #1;
        check_value(32'(di_ready_o), 32'd1, "di_ready_o on a bypass hit");
        check_value(fu_rs1val_o, value, "rs1 from the bypass");
        issue_now(rid);
        pending.push_back(rid);
        byp_valid_i = 1'b0;
        wb_valid_i  = 1'b1;
        wb_prd_i    = 6'd10;
        wb_rdval_i  = value;
        @(negedge clk);
        wb_valid_i = 1'b0;
        // Same source again now served by the PRF
        present_plain(8'h32, 32'h0000_1108);
        di_rs1_valid_i    = 1'b1;
        di_rs1_i          = 5'd9;
        di_prs1_i         = 6'd10;
        di_prs1_renamed_i = 1'b1;
        #1;
        check_value(32'(di_ready_o), 32'd1, "di_ready_o after writeback");
        check_value(fu_rs1val_o, value, "rs1 from the PRF");
        issue_now(rid);
        pending.push_back(rid);
        drain_rob();
    endtask

    task automatic fu_backpressure();
        rob_id_t rid;
        present_plain(8'h40, 32'h0000_1800);
        di_fu_i            = FU_MUL;
        fu_ready_i[FU_MUL] = 1'b0;
        #1;
        check_value(32'(di_ready_o), 32'd0, "di_ready_o with the MUL busy");
        check_value(32'(fu_valid_o), 32'd0, "fu_valid_o with the MUL busy");
        @(negedge clk);
        check_value(32'(fu_valid_o), 32'd0, "fu_valid_o while held");
        fu_ready_i[FU_MUL] = 1'b1;
        issue_now(rid);
        pending.push_back(rid);
        drain_rob();
    endtask

    task automatic rob_full_in_order();
        rob_id_t rids [DEPTH];
        xlen_t   vals [DEPTH];
        for (int i = 0; i < DEPTH; i++) begin
            present_plain(inst_id_t'(80 + i), xlen_t'(32'h2000 + 4 * i));
            di_rd_valid_i = 1'b1;
            di_rd_i       = areg_id_t'(i + 1);
            di_prd_i      = preg_id_t'(30 + i);
            issue_now(rids[i]);
        end
        present_plain(8'h58, 32'h0000_2020);
        #1;
        check_value(32'(di_ready_o), 32'd0, "di_ready_o with the ROB full");
        check_value(32'(fu_valid_o), 32'd0, "fu_valid_o with the ROB full");
        idle_inputs();
        for (int i = 0; i < DEPTH; i++) begin
            vals[i]    = next_random();
            wb_valid_i = 1'b1;
            wb_prd_i   = preg_id_t'(30 + i);
            wb_rdval_i = vals[i];
            @(negedge clk);
        end
        wb_valid_i = 1'b0;
        // Youngest first so nothing may retire before the oldest is done
        for (int i = DEPTH - 1; i >= 0; i--) begin
            check_value(32'(retire_valid_o), 32'd0, "retire before the oldest completed");
            complete_entry(rids[i]);
        end
        check_value(32'(retire_valid_o), 32'd0, "retire_valid_o one edge after completion");
        @(negedge clk);
        for (int i = 0; i < DEPTH; i++) begin
            check_value(32'(retire_valid_o), 32'd1, "retire_valid_o in the burst");
            check_value(32'(retire_id_o), 32'(80 + i), "retire_id_o in issue order");
            check_value(32'(retire_ard_o), 32'(i + 1), "retire_ard_o in issue order");
            check_value(32'(retire_prd_o), 32'(30 + i), "retire_prd_o in issue order");
            check_value(retire_rdval_o, vals[i], "retire_rdval_o in issue order");
            @(negedge clk);
        end
        check_value(32'(retire_valid_o), 32'd0, "retire_valid_o after the burst");
        drain_rob();
    endtask

    initial begin
        rstn = 1'b0;
        idle_inputs();
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        reset_and_operand_select();
        write_complete_commit();
        scoreboard_stall_bypass();
        fu_backpressure();
        rob_full_in_order();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
